// ==== bench/lcd_checker.sv ====
// lcd controller checker for pin stability, reset and busy rules on the LCD pins
`timescale 1ns/1ns
`default_nettype none

module lcd_checker (
	input logic               clk,
	input logic               reset_i,
	input logic               lcd_en_i,
	input logic               lcd_rs_i,
	input lcd_pkg::lcd_byte_t lcd_data_i,
	input logic               waitrequest_i
);

	int stable_fails = 0; // failure tallies with one per rule
	int reset_fails  = 0;
	int busy_fails   = 0;

	// rs and data settle in the setup cycle and hold until enable falls
	property pins_stable_p;
		@(posedge clk) disable iff (reset_i)
			lcd_en_i |-> ($stable(lcd_data_i) && $stable(lcd_rs_i));
	endproperty

	// enable only rises out of an edge where reset was low
	property no_en_in_reset_p;
		@(posedge clk) $rose(lcd_en_i) |-> !$past(reset_i);
	endproperty

	// slave stays busy for the whole pulse
	property busy_during_en_p;
		@(posedge clk) disable iff (reset_i)
			lcd_en_i |-> waitrequest_i;
	endproperty

	pins_stable_a: assert property (pins_stable_p)
		else begin
			$error("lcd data or rs changed while enable was high");
			stable_fails++;
		end

	no_en_in_reset_a: assert property (no_en_in_reset_p)
		else begin
			$error("lcd enable rose while reset was asserted");
			reset_fails++;
		end

	busy_during_en_a: assert property (busy_during_en_p)
		else begin
			$error("waitrequest low while lcd enable was high");
			busy_fails++;
		end

endmodule

bind lcd_char_ctrl lcd_checker ctrl_checker_inst (
	.clk           (clk),
	.reset_i       (reset_i),
	.lcd_en_i      (lcd_en_o),
	.lcd_rs_i      (lcd_rs_o),
	.lcd_data_i    (lcd_data_o),
	.waitrequest_i (waitrequest_o)
);

`default_nettype wire

// ==== bench/lcd_tb.sv ====
// lcd testbench driving random filter modes against a pin capture model of the message sequence
`timescale 1ns/1ns
`default_nettype none

module lcd_tb;

	localparam int EN_CYCLES    = 4;
	localparam int HOLD_CYCLES  = 6;
	localparam int XFER_CYCLES  = EN_CYCLES + HOLD_CYCLES + 2; // min spacing of enable rises
	localparam int MSG_XFERS    = lcd_pkg::MSG_LEN + 2;         // clear, home, sixteen chars
	localparam int FULL_CYCLES  = XFER_CYCLES * (MSG_XFERS + 1) + 8; // worst case change to end
	localparam int QUIET_CYCLES = 3 * XFER_CYCLES;              // idle time after a full line
	localparam int NUM_DWELLS   = 12;
	localparam int SEED         = 47284;

	logic               clk;
	logic               reset_i;
	lcd_pkg::lcd_mode_t mode;
	lcd_pkg::lcd_byte_t lcd_data;
	logic               lcd_rs;
	logic               lcd_en;

	lcd_pkg::lcd_mode_t modes [NUM_DWELLS]; // random schedule
	int                 dwells [NUM_DWELLS];
	int                 wd_cycles = 0;      // watchdog budget in cycles, zero until known

	// capture model state updated on rising clock edges
	int                 errors = 0;
	int                 checks = 0;
	int                 pulses = 0;
	int                 cycle;
	int                 since_change; // edges since the DUT last saw a new mode
	int                 gen;          // count of mode changes
	int                 gen_q1, gen_q2;
	int                 rise_cycle;
	int                 rise_gen;     // change count at the edge that accepted the write
	int                 exp_idx;      // next item of the line where 0 is clear
	logic               en_q;
	logic               have_rise;
	lcd_pkg::lcd_mode_t last_mode;
	lcd_pkg::lcd_mode_t exp_mode;

	lcd_display_top #(
		.EN_CYCLES   (EN_CYCLES),
		.HOLD_CYCLES (HOLD_CYCLES)
	) lcd_display_top_inst (
		.clk        (clk),
		.reset_i    (reset_i),
		.mode_i     (mode),
		.lcd_data_o (lcd_data),
		.lcd_rs_o   (lcd_rs),
		.lcd_en_o   (lcd_en)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	task automatic check_equal(input int got, input int expected, input string what);
		checks++;
		if (got != expected) begin
			errors++;
			$display("MISMATCH at %0t ns: %s, got 0x%0h, expected 0x%0h",
				$time, what, got, expected);
		end
	endtask

	// byte of item idx in the line of mode m
	function automatic int expected_byte(input lcd_pkg::lcd_mode_t m, input int idx);
		logic [3:0] pos;
		pos = 4'(idx - 2); // text position once both commands are out
		if (idx == 0)
			return int'(lcd_pkg::CMD_CLEAR);
		else if (idx == 1)
			return int'(lcd_pkg::CMD_HOME_LINE1);
		else
			return int'(lcd_pkg::MSG_TEXT[m][pos]);
	endfunction

	function automatic int assertion_failures();
		return lcd_display_top_inst.ctrl_inst.ctrl_checker_inst.stable_fails
			+ lcd_display_top_inst.ctrl_inst.ctrl_checker_inst.reset_fails
			+ lcd_display_top_inst.ctrl_inst.ctrl_checker_inst.busy_fails;
	endfunction

	task automatic wait_message_done();
		while (exp_idx < MSG_XFERS)
			@(negedge clk); // watchdog ends a stuck line
	endtask

	// pin capture with sampled values from the cycle before the edge
	always @(posedge clk) begin
		if (reset_i) begin
			cycle        = 0;
			since_change = 0;
			gen          = 0;
			gen_q1       = 0;
			gen_q2       = 0;
			rise_cycle   = 0;
			rise_gen     = 0;
			exp_idx      = 0;
			en_q         = 1'b0;
			have_rise    = 1'b0;
			last_mode    = mode; // arbiter history loads the reset mode
			exp_mode     = mode;
		end else begin
			cycle++;
			since_change++;
			if (mode != last_mode) begin // new line starts from clear
				gen++;
				last_mode    = mode;
				exp_mode     = mode;
				exp_idx      = 0;
				since_change = 0;
			end
			if (lcd_en && !en_q) begin // rose one edge ago and the write went in before that
				if (have_rise)
					check_equal(int'(cycle - rise_cycle >= XFER_CYCLES), 1,
						$sformatf("enable rises only %0d cycles apart", cycle - rise_cycle));
				have_rise  = 1'b1;
				rise_cycle = cycle;
				rise_gen   = gen_q2;
			end
			if (!lcd_en && en_q) begin // pulse over while the pins still hold its item
				pulses++;
				check_equal(cycle - rise_cycle, EN_CYCLES, "enable pulse width in cycles");
				if (rise_gen == gen) begin // older pulses belong to the previous mode
					check_equal(int'(exp_idx < MSG_XFERS), 1,
						"enable pulse after the line was complete");
					if (exp_idx < MSG_XFERS) begin
						check_equal(int'(lcd_rs), (exp_idx >= 2) ? 1 : 0,
							$sformatf("mode %0d item %0d rs", exp_mode, exp_idx));
						check_equal(int'(lcd_data), expected_byte(exp_mode, exp_idx),
							$sformatf("mode %0d item %0d data", exp_mode, exp_idx));
						exp_idx++;
					end
				end
			end
			en_q   = lcd_en;
			gen_q2 = gen_q1;
			gen_q1 = gen;
		end
	end

	// stimulus changes inputs on falling edges only
	initial begin
		int budget;
		void'($urandom(SEED));
		reset_i = 1'b1;
		mode    = lcd_pkg::lcd_mode_t'($urandom % 4);
		budget  = 16 + 3 * FULL_CYCLES + 2 * QUIET_CYCLES + 200;
		for (int i = 0; i < NUM_DWELLS; i++) begin
			modes[i] = lcd_pkg::lcd_mode_t'($urandom % 4);
			if ($urandom % 2 == 0)
				dwells[i] = 16 + int'($urandom % (FULL_CYCLES / 2)); // cut the line short
			else
				dwells[i] = FULL_CYCLES + int'($urandom % 64);      // room for the whole line
			budget += dwells[i];
		end
		wd_cycles = budget;

		repeat (8) @(negedge clk);
		reset_i = 1'b0;
		while (exp_idx < 4)
			@(negedge clk); // a few items of the line out
		while (!lcd_en)
			@(negedge clk); // first enable cycle of the next item
		reset_i = 1'b1;       // reset in the middle of a pulse
		repeat (8) @(negedge clk);
		reset_i = 1'b0;
		wait_message_done();                  // line of the reset mode
		repeat (QUIET_CYCLES) @(negedge clk); // nothing more may follow

		for (int i = 0; i < NUM_DWELLS; i++) begin
			mode = modes[i];
			repeat (dwells[i]) @(negedge clk);
			if (since_change >= FULL_CYCLES)
				check_equal(exp_idx, MSG_XFERS,
					$sformatf("items of mode %0d after a full dwell", exp_mode));
		end
		wait_message_done();
		repeat (QUIET_CYCLES) @(negedge clk);

		$display("Summary: %0d errors, %0d assertion failures, %0d checks, %0d pulses",
			errors, assertion_failures(), checks, pulses);
		if (errors == 0 && assertion_failures() == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// watchdog with a budget from the summed dwells plus margin
	initial begin
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge clk);
		$display("ERROR: run timed out, no finish within %0d cycles", wd_cycles);
		$display("Summary: %0d errors, %0d assertion failures, %0d checks, %0d pulses",
			errors, assertion_failures(), checks, pulses);
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the lcd testbench with Verilator, run it, judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --top-module lcd_tb -f verilog.f -Mdir obj_dir -o lcd_sim \
	&& ./obj_dir/lcd_sim > sim.log 2>&1 \
	|| echo "build or simulation ended with an error"

cat sim.log 2>/dev/null

# the pass line must appear on its own in the log
grep -qx "All checks passed" sim.log 2>/dev/null \
	&& echo "RESULT: PASS" \
	&& exit 0 \
	|| echo "RESULT: FAIL"
exit 1

// ==== source/lcd_bus_arbiter.sv ====
// lcd bus arbiter: restarts writers on mode change, routes the selected writer to the controller
`timescale 1ns/1ns
`default_nettype none

module lcd_bus_arbiter (
	input  logic                 clk,
	input  logic                 reset_i,
	input  lcd_pkg::lcd_mode_t   mode_i,
	output logic                 restart_o,
	// writer 0, colour
	input  logic                 chipselect0_i,
	input  logic                 write0_i,
	input  logic                 address0_i,
	input  lcd_pkg::lcd_byte_t   writedata0_i,
	output logic                 wait0_o,
	// writer 1, blur
	input  logic                 chipselect1_i,
	input  logic                 write1_i,
	input  logic                 address1_i,
	input  lcd_pkg::lcd_byte_t   writedata1_i,
	output logic                 wait1_o,
	// writer 2, brightness
	input  logic                 chipselect2_i,
	input  logic                 write2_i,
	input  logic                 address2_i,
	input  lcd_pkg::lcd_byte_t   writedata2_i,
	output logic                 wait2_o,
	// writer 3, edge detect
	input  logic                 chipselect3_i,
	input  logic                 write3_i,
	input  logic                 address3_i,
	input  lcd_pkg::lcd_byte_t   writedata3_i,
	output logic                 wait3_o,
	// shared side towards the controller
	output logic                 cs_o,
	output logic                 wr_o,
	output logic                 addr_o,
	output lcd_pkg::lcd_byte_t   wdata_o,
	input  logic                 waitrequest_i
);

	lcd_pkg::lcd_mode_t mode_q0;  // mode one cycle back
	lcd_pkg::lcd_mode_t mode_q1;  // mode two cycles back
	logic [1:0]         post_rst; // stretches restart two cycles past reset
	logic               sel_cs;   // chipselect of the selected writer

	// two-stage history, so a change gives two cycles of restart
	always_ff @(posedge clk) begin
		if (reset_i) begin
			mode_q0  <= mode_i; // history matches mode at reset
			mode_q1  <= mode_i;
			post_rst <= 2'b11;
		end else begin
			mode_q0  <= mode_i;
			mode_q1  <= mode_q0;
			post_rst <= {post_rst[0], 1'b0};
		end
	end

	assign restart_o = reset_i || post_rst[1] || (mode_q1 != mode_i);

	// mux the writer picked by the current mode
	always_comb begin
		unique case (mode_i)
			2'd0: begin
				sel_cs  = chipselect0_i;
				wr_o    = write0_i;
				addr_o  = address0_i;
				wdata_o = writedata0_i;
			end
			2'd1: begin
				sel_cs  = chipselect1_i;
				wr_o    = write1_i;
				addr_o  = address1_i;
				wdata_o = writedata1_i;
			end
			2'd2: begin
				sel_cs  = chipselect2_i;
				wr_o    = write2_i;
				addr_o  = address2_i;
				wdata_o = writedata2_i;
			end
			default: begin // mode 3
				sel_cs  = chipselect3_i;
				wr_o    = write3_i;
				addr_o  = address3_i;
				wdata_o = writedata3_i;
			end
		endcase
	end

	assign cs_o = sel_cs && !restart_o; // nothing reaches the LCD mid restart

	// only the selected writer sees the real wait, the rest stall
	assign wait0_o = (mode_i != 2'd0) || waitrequest_i;
	assign wait1_o = (mode_i != 2'd1) || waitrequest_i;
	assign wait2_o = (mode_i != 2'd2) || waitrequest_i;
	assign wait3_o = (mode_i != 2'd3) || waitrequest_i;

endmodule

`default_nettype wire

// ==== source/lcd_char_ctrl.sv ====
// character lcd controller: turns each bus write into register select, data and enable timing
`timescale 1ns/1ns
`default_nettype none

module lcd_char_ctrl #(
	parameter int EN_CYCLES   = 4, // enable pulse width in clocks, at least 1
	parameter int HOLD_CYCLES = 6  // wait after enable falls before next write
) (
	input  logic                 clk,
	input  logic                 reset_i,
	input  logic                 chipselect_i,
	input  logic                 write_i,
	input  logic                 address_i,    // 0 command, 1 character data
	input  lcd_pkg::lcd_byte_t   writedata_i,
	output logic                 waitrequest_o,
	output lcd_pkg::lcd_byte_t   lcd_data_o,
	output logic                 lcd_rs_o,
	output logic                 lcd_en_o
);

	// counter sized for the longer of the two phases
	localparam int MAX_CYCLES = (EN_CYCLES > HOLD_CYCLES) ? EN_CYCLES : HOLD_CYCLES;
	localparam int CNT_W      = $clog2(MAX_CYCLES + 1);

	localparam logic [CNT_W-1:0] EN_LOAD   = CNT_W'(EN_CYCLES - 1);
	localparam logic [CNT_W-1:0] HOLD_LOAD = CNT_W'((HOLD_CYCLES > 0) ? HOLD_CYCLES - 1 : 0);

	typedef enum logic [1:0] {
		ST_IDLE,   // ready, waitrequest low
		ST_SETUP,  // rs and data settle before enable
		ST_ENABLE, // enable high
		ST_HOLD    // enable low, LCD still busy
	} state_t;

	state_t           state;
	logic [CNT_W-1:0] cnt;    // cycles left in the current phase
	logic             accept; // write taken this cycle

	assign accept = (state == ST_IDLE) && chipselect_i && write_i;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state      <= ST_IDLE;
			cnt        <= '0;
			lcd_rs_o   <= 1'b0;
			lcd_data_o <= '0;
		end else begin
			unique case (state)
				ST_IDLE: begin
					if (accept) begin
						lcd_rs_o   <= address_i;   // address bit is register select
						lcd_data_o <= writedata_i; // held until next accepted write
						state      <= ST_SETUP;
					end
				end
				ST_SETUP: begin
					state <= ST_ENABLE; // one cycle of setup before enable rises
					cnt   <= EN_LOAD;
				end
				ST_ENABLE: begin
					if (cnt == '0) begin
						if (HOLD_CYCLES > 0) begin
							state <= ST_HOLD;
							cnt   <= HOLD_LOAD;
						end else begin
							state <= ST_IDLE; // no hold time configured
						end
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				ST_HOLD: begin
					if (cnt == '0)
						state <= ST_IDLE;
					else
						cnt <= cnt - 1'b1;
				end
			endcase
		end
	end

	// busy from the cycle after acceptance until hold time ends
	assign waitrequest_o = (state != ST_IDLE);

	// enable straight from the state register, EN_CYCLES wide
	assign lcd_en_o = (state == ST_ENABLE);

endmodule

`default_nettype wire

// ==== source/lcd_display_top.sv ====
// lcd display top: four filter message writers, mode arbiter and the character lcd controller
`timescale 1ns/1ns
`default_nettype none

module lcd_display_top #(
	parameter int EN_CYCLES   = 4, // enable pulse width
	parameter int HOLD_CYCLES = 6  // busy time after enable
) (
	input  logic                 clk,
	input  logic                 reset_i,
	input  lcd_pkg::lcd_mode_t   mode_i,
	output lcd_pkg::lcd_byte_t   lcd_data_o,
	output logic                 lcd_rs_o,
	output logic                 lcd_en_o
);

	logic               restart;               // from arbiter to all writers
	logic [3:0]         w_cs;                  // per writer bus signals
	logic [3:0]         w_wr;
	logic [3:0]         w_addr;
	logic [3:0]         w_wait;
	lcd_pkg::lcd_byte_t w_data [0:3];
	logic               cs, wr, addr, waitreq; // shared bus to controller
	lcd_pkg::lcd_byte_t wdata;

	// one writer per filter mode, row picked by loop index
	for (genvar i = 0; i < 4; i++) begin : g_writer
		lcd_msg_writer #(
			.MSG_SEL (i)
		) writer_inst (
			.clk           (clk),
			.restart_i     (restart),
			.waitrequest_i (w_wait[i]),
			.chipselect_o  (w_cs[i]),
			.write_o       (w_wr[i]),
			.address_o     (w_addr[i]),
			.writedata_o   (w_data[i])
		);
	end

	lcd_bus_arbiter arbiter_inst (
		.clk           (clk),
		.reset_i       (reset_i),
		.mode_i        (mode_i),
		.restart_o     (restart),
		.chipselect0_i (w_cs[0]),
		.write0_i      (w_wr[0]),
		.address0_i    (w_addr[0]),
		.writedata0_i  (w_data[0]),
		.wait0_o       (w_wait[0]),
		.chipselect1_i (w_cs[1]),
		.write1_i      (w_wr[1]),
		.address1_i    (w_addr[1]),
		.writedata1_i  (w_data[1]),
		.wait1_o       (w_wait[1]),
		.chipselect2_i (w_cs[2]),
		.write2_i      (w_wr[2]),
		.address2_i    (w_addr[2]),
		.writedata2_i  (w_data[2]),
		.wait2_o       (w_wait[2]),
		.chipselect3_i (w_cs[3]),
		.write3_i      (w_wr[3]),
		.address3_i    (w_addr[3]),
		.writedata3_i  (w_data[3]),
		.wait3_o       (w_wait[3]),
		.cs_o          (cs),
		.wr_o          (wr),
		.addr_o        (addr),
		.wdata_o       (wdata),
		.waitrequest_i (waitreq)
	);

	// controller only sees the board reset, a restart lets the pin transfer finish
	lcd_char_ctrl #(
		.EN_CYCLES   (EN_CYCLES),
		.HOLD_CYCLES (HOLD_CYCLES)
	) ctrl_inst (
		.clk           (clk),
		.reset_i       (reset_i),
		.chipselect_i  (cs),
		.write_i       (wr),
		.address_i     (addr),
		.writedata_i   (wdata),
		.waitrequest_o (waitreq),
		.lcd_data_o    (lcd_data_o),
		.lcd_rs_o      (lcd_rs_o),
		.lcd_en_o      (lcd_en_o)
	);

endmodule

`default_nettype wire

// ==== source/lcd_msg_writer.sv ====
// lcd message writer: sends clear, home and one filter's sixteen characters as bus writes
`timescale 1ns/1ns
`default_nettype none

module lcd_msg_writer #(
	parameter int MSG_SEL = 0 // row of MSG_TEXT to send
) (
	input  logic                 clk,
	input  logic                 restart_i,     // acts as reset, restarts the message
	input  logic                 waitrequest_i, // back-pressure from arbiter
	output logic                 chipselect_o,
	output logic                 write_o,
	output logic                 address_o,     // 0 command, 1 character data
	output lcd_pkg::lcd_byte_t   writedata_o
);

	localparam int IDX_W = $clog2(lcd_pkg::MSG_LEN);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(lcd_pkg::MSG_LEN - 1);

	typedef enum logic [1:0] {
		ST_CLEAR, // clear command pending
		ST_HOME,  // cursor home pending
		ST_CHARS, // walking the message text
		ST_DONE   // whole line written, wait for restart
	} state_t;

	state_t           state;
	logic [IDX_W-1:0] char_idx; // next character to send
	logic             cs_q;     // registered chipselect
	logic             accepted; // current item taken by the slave

	// transfer completes on an edge with cs high and no wait
	assign accepted = cs_q && !waitrequest_i;

	always_ff @(posedge clk) begin
		if (restart_i) begin
			state    <= ST_CLEAR;
			char_idx <= '0;
			cs_q     <= 1'b0; // bus released while restarting
		end else begin
			cs_q <= (state != ST_DONE); // raise cs the cycle after restart drops
			if (accepted) begin
				unique case (state)
					ST_CLEAR: state <= ST_HOME;
					ST_HOME: begin
						state    <= ST_CHARS;
						char_idx <= '0;
					end
					ST_CHARS: begin
						if (char_idx == LAST_IDX) begin
							state <= ST_DONE;
							cs_q  <= 1'b0; // drop cs right after the last char
						end else begin
							char_idx <= char_idx + 1'b1;
						end
					end
					ST_DONE: state <= ST_DONE; // cs already low here
				endcase
			end
		end
	end

	// write is only ever issued together with chipselect
	assign chipselect_o = cs_q;
	assign write_o      = cs_q;

	// register select: commands first, then text
	assign address_o = (state == ST_CHARS);

	// byte for the current item, held steady until accepted
	always_comb begin
		unique case (state)
			ST_CLEAR: writedata_o = lcd_pkg::CMD_CLEAR;
			ST_HOME:  writedata_o = lcd_pkg::CMD_HOME_LINE1;
			default:  writedata_o = lcd_pkg::MSG_TEXT[MSG_SEL][char_idx]; // chars, done
		endcase
	end

endmodule

`default_nettype wire

// ==== source/lcd_pkg.sv ====
// lcd package: mode and byte types, LCD command codes, filter message texts
`default_nettype none

package lcd_pkg;

	// filter mode from the board switches
	// 00 colour, 01 blur, 10 brightness, 11 edge detect
	typedef logic [1:0] lcd_mode_t;

	// one command or character byte on the LCD bus
	typedef logic [7:0] lcd_byte_t;

	localparam int MSG_LEN = 16; // characters per message, one full line

	// controller commands, sent with register select low
	localparam lcd_byte_t CMD_CLEAR      = 8'h01; // clear display
	localparam lcd_byte_t CMD_HOME_LINE1 = 8'h80; // ddram addr 0, start of line one

	// one line of text, element 0 is the leftmost character
	typedef lcd_byte_t [0:MSG_LEN-1] lcd_msg_t;

	// message per mode, space padded out to MSG_LEN
	// row index follows lcd_mode_t encoding
	localparam lcd_msg_t MSG_TEXT [0:3] = '{
		"COLOUR FILTER   ", // mode 00
		"BLUR FILTER     ", // mode 01
		"BRIGHTNESS      ", // mode 10
		"EDGE DETECT     "  // mode 11
	};

endpackage

`default_nettype wire

// ==== verilog.f ====
source/lcd_pkg.sv
source/lcd_msg_writer.sv
source/lcd_bus_arbiter.sv
source/lcd_char_ctrl.sv
source/lcd_display_top.sv
bench/lcd_checker.sv
bench/lcd_tb.sv
